//--- sim.f
+incdir+design
design/slow_ctrl_pkg.sv
design/serial_req_arbiter.sv
design/spi_shift_engine.sv
design/serial_pin_router.sv
design/slow_ctrl_top.sv
sim/serial_dev_models.sv
sim/tb_slow_ctrl.sv

//--- sim/tb_slow_ctrl.sv
/*
 * testbench for the slow serial control top
 * reset levels, ADC writes with readback, DAC writes per bus,
 * and both clients requesting in the same cycle
 */
`include "slow_ctrl_consts.svh"

module tb_slow_ctrl;

  localparam int ADC_FRAME = `CS_LEAD + 2 * `ADC_WORD_BITS * `SCLK_HALF + `CS_TAIL;
  localparam int DAC_FRAME = `CS_LEAD + 2 * `DAC_WORD_BITS * `SCLK_HALF + `CS_TAIL;
  // seven ADC and four DAC frames, plus half again for gaps
  localparam int MAX_CYCLES = (7 * ADC_FRAME + 4 * DAC_FRAME) * 3 / 2;

  logic                                        lclk = 1'b0;
  logic                                        lclk_rst;
  logic                                        i_adc_req;
  logic [`N_ADC_CHIPS-1:0]                     i_adc_sel;
  logic [`ADC_WORD_BITS-1:0]                   i_adc_wr_data;
  logic                                        i_adc_sdout;
  logic                                        o_adc_ack;
  logic [`ADC_RD_BITS-1:0]                     o_adc_rd_data;
  logic                                        o_adc_sclk;
  logic                                        o_adc_sdata;
  logic [`N_ADC_CHIPS-1:0]                     o_adc_sen_n;
  logic                                        i_dac_req;
  logic [`N_DAC_BUSES-1:0]                     i_dac_bus_sel;
  logic [`N_DAC_CHIPS-1:0]                     i_dac_chip_sel;
  logic [`DAC_WORD_BITS-1:0]                   i_dac_wr_data;
  logic                                        o_dac_ack;
  logic [`N_DAC_BUSES-1:0]                     o_dac_sclk;
  logic [`N_DAC_BUSES-1:0]                     o_dac_din;
  logic [`N_DAC_BUSES*`N_DAC_CHIPS-1:0]        o_dac_sync_n;
  // model side
  logic [`ADC_WORD_BITS-1:0]                   adc_resp;
  logic [`N_ADC_CHIPS-1:0]                     adc_sen_seen;
  logic [`ADC_WORD_BITS-1:0]                   adc_rx;
  logic [7:0]                                  adc_edges;
  logic [`N_DAC_BUSES*`N_DAC_CHIPS-1:0]        dac_sync_seen;
  logic [`N_DAC_BUSES-1:0][`DAC_WORD_BITS-1:0] dac_rx;
  logic [`N_DAC_BUSES-1:0][7:0]                dac_edges;
  int                                          pin_errs;
  int                                          errors = 0;
  int                                          cycles = 0;
  int                                          seed   = 61426;

  always #5 lclk = ~lclk;

  slow_ctrl_top dut (.*);

  serial_dev_models u_models (
    .lclk            (lclk),
    .i_adc_sclk      (o_adc_sclk),
    .i_adc_sdata     (o_adc_sdata),
    .i_adc_sen_n     (o_adc_sen_n),
    .i_adc_resp      (adc_resp),
    .i_dac_sclk      (o_dac_sclk),
    .i_dac_din       (o_dac_din),
    .i_dac_sync_n    (o_dac_sync_n),
    .o_adc_sdout     (i_adc_sdout),
    .o_adc_sen_seen  (adc_sen_seen),
    .o_adc_rx        (adc_rx),
    .o_adc_edges     (adc_edges),
    .o_dac_sync_seen (dac_sync_seen),
    .o_dac_rx        (dac_rx),
    .o_dac_edges     (dac_edges),
    .o_err_cnt       (pin_errs)
  );

  // hard stop in case an ack never comes
  always @(posedge lclk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: no end of test after %0d cycles, %0d errors so far",
               cycles, errors + pin_errs);
      $display("Something failed");
      $finish;
    end
  end

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else begin
      errors++;
      $display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic check_latency(input int got, input int bound, input string what);
    assert (got <= bound) else begin
      errors++;
      $display("at %0t the %s took %0d cycles, more than the %0d allowed", $time, what,
               got, bound);
    end
  endtask

  // raise requests, drop each one after its ack, return the ack cycle counts
  task automatic run_requests(input bit do_adc, input bit do_dac, output int adc_at,
                              output int dac_at);
    int n;
    n      = 0;
    adc_at = 0;
    dac_at = 0;
    i_adc_req = do_adc;
    i_dac_req = do_dac;
    while ((do_adc && adc_at == 0) || (do_dac && dac_at == 0)) begin
      @(negedge lclk);
      n++;
      if (o_adc_ack) begin
        adc_at    = n;
        i_adc_req = 1'b0;
      end
      if (o_dac_ack) begin
        dac_at    = n;
        i_dac_req = 1'b0;
      end
    end
    // acks are single pulses and the pins are released by now
    @(negedge lclk);
    check_value({o_adc_ack, o_dac_ack}, 2'b00, "acks after the pulse");
    check_value(o_adc_sen_n, 6'h3f, "ADC enables after ack");
    check_value(o_dac_sync_n, 9'h1ff, "DAC syncs after ack");
  endtask

  task automatic adc_write(input int chip, input logic [`ADC_WORD_BITS-1:0] data,
                           input logic [`ADC_WORD_BITS-1:0] resp);
    int                      adc_at;
    int                      dac_at;
    logic [`N_ADC_CHIPS-1:0] exp_sen;
    i_adc_sel     = `N_ADC_CHIPS'(1) << chip;
    i_adc_wr_data = data;
    adc_resp      = resp;
    exp_sen       = ~i_adc_sel;
    run_requests(1'b1, 1'b0, adc_at, dac_at);
    check_value(adc_sen_seen, exp_sen, "ADC enables in frame");
    check_value(adc_edges, `ADC_WORD_BITS, "ADC rising edge count");
    check_value(adc_rx, data, "ADC word at the chip");
    check_value(o_adc_rd_data, resp[`ADC_RD_BITS-1:0], "ADC read data");
    check_value(dac_at, 0, "DAC ack during ADC write");
    check_latency(adc_at - 1, 3 + ADC_FRAME, "ADC ack");
  endtask

  task automatic dac_write(input int bus, input logic [`N_DAC_CHIPS-1:0] chips,
                           input logic [`DAC_WORD_BITS-1:0] data);
    int                                   adc_at;
    int                                   dac_at;
    logic [`N_DAC_BUSES*`N_DAC_CHIPS-1:0] exp_sync;
    i_dac_bus_sel  = `N_DAC_BUSES'(1) << bus;
    i_dac_chip_sel = chips;
    i_dac_wr_data  = data;
    exp_sync       = '1;
    exp_sync[bus*`N_DAC_CHIPS +: `N_DAC_CHIPS] = ~chips;
    run_requests(1'b0, 1'b1, adc_at, dac_at);
    check_value(dac_sync_seen, exp_sync, "DAC syncs in frame");
    check_value(dac_edges[bus], `DAC_WORD_BITS, "DAC falling edge count");
    check_value(dac_rx[bus], data, "DAC word at the chip");
    check_value(adc_at, 0, "ADC ack during DAC write");
    check_latency(dac_at - 1, 3 + DAC_FRAME, "DAC ack");
  endtask

  initial begin
    int                        adc_at;
    int                        dac_at;
    logic [`N_DAC_CHIPS-1:0]   chips;
    logic [`ADC_WORD_BITS-1:0] adc_word;
    logic [`ADC_WORD_BITS-1:0] resp;
    logic [`DAC_WORD_BITS-1:0] dac_word;
    lclk_rst       = 1'b1;
    i_adc_req      = 1'b0;
    i_adc_sel      = '0;
    i_adc_wr_data  = '0;
    i_dac_req      = 1'b0;
    i_dac_bus_sel  = '0;
    i_dac_chip_sel = '0;
    i_dac_wr_data  = '0;
    adc_resp       = '0;
    repeat (2) @(negedge lclk);
    lclk_rst = 1'b0;

    // inactive pin levels straight out of reset
    check_value({o_adc_ack, o_dac_ack}, 2'b00, "acks after reset");
    check_value(o_adc_sen_n, 6'h3f, "ADC enables after reset");
    check_value(o_dac_sync_n, 9'h1ff, "DAC syncs after reset");
    check_value({o_adc_sclk, o_adc_sdata}, 2'b00, "ADC clock and data after reset");
    check_value(o_dac_sclk, 3'h7, "DAC clocks after reset");
    check_value(o_dac_din, 3'h0, "DAC data after reset");
    check_value(o_adc_rd_data, 8'h00, "ADC read data after reset");

    // every ADC chip once
    for (int c = 0; c < `N_ADC_CHIPS; c++) begin
      adc_word = $random(seed);
      resp     = $random(seed);
      adc_write(c, adc_word, resp);
    end

    // every DAC bus once, random non-empty chip set
    for (int b = 0; b < `N_DAC_BUSES; b++) begin
      chips    = $random(seed);
      dac_word = $random(seed);
      if (chips == '0) begin
        chips = 3'b001;
      end
      dac_write(b, chips, dac_word);
    end

    // both clients in the same cycle, ADC goes first
    adc_word       = $random(seed);
    resp           = $random(seed);
    dac_word       = $random(seed);
    i_adc_sel      = 6'b001000;
    i_adc_wr_data  = adc_word;
    adc_resp       = resp;
    i_dac_bus_sel  = 3'b010;
    i_dac_chip_sel = 3'b101;
    i_dac_wr_data  = dac_word;
    run_requests(1'b1, 1'b1, adc_at, dac_at);
    assert (adc_at != 0 && adc_at < dac_at) else begin
      errors++;
      $display("at %0t the DAC request was served before the ADC request", $time);
    end
    check_latency(adc_at - 1, 3 + ADC_FRAME, "ADC ack under contention");
    check_latency(dac_at - 1, ADC_FRAME + 3 + DAC_FRAME, "DAC ack under contention");
    check_value(adc_rx, adc_word, "ADC word under contention");
    check_value(o_adc_rd_data, resp[`ADC_RD_BITS-1:0], "ADC read data under contention");
    check_value(dac_rx[1], dac_word, "DAC word under contention");

    $display("errors: %0d testbench, %0d pin model", errors, pin_errs);
    if (errors + pin_errs == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- sim/serial_dev_models.sv
/*
 * behavioural serial bus receivers
 * ADC bus receiver with MSB-first readback, one receiver per DAC bus,
 * and checks on idle pin levels and enable/sync overlap
 */
`include "slow_ctrl_consts.svh"

module serial_dev_models (
  input  logic                                        lclk,
  input  logic                                        i_adc_sclk,
  input  logic                                        i_adc_sdata,
  input  logic [`N_ADC_CHIPS-1:0]                     i_adc_sen_n,
  input  logic [`ADC_WORD_BITS-1:0]                   i_adc_resp,
  input  logic [`N_DAC_BUSES-1:0]                     i_dac_sclk,
  input  logic [`N_DAC_BUSES-1:0]                     i_dac_din,
  input  logic [`N_DAC_BUSES*`N_DAC_CHIPS-1:0]        i_dac_sync_n,
  output logic                                        o_adc_sdout,
  output logic [`N_ADC_CHIPS-1:0]                     o_adc_sen_seen,
  output logic [`ADC_WORD_BITS-1:0]                   o_adc_rx,
  output logic [7:0]                                  o_adc_edges,
  output logic [`N_DAC_BUSES*`N_DAC_CHIPS-1:0]        o_dac_sync_seen,
  output logic [`N_DAC_BUSES-1:0][`DAC_WORD_BITS-1:0] o_dac_rx,
  output logic [`N_DAC_BUSES-1:0][7:0]                o_dac_edges,
  output int                                          o_err_cnt
);

  int                      err_cnt    = 0;
  int                      rd_idx     = 0;
  logic                    sdout_q    = 1'b0;
  logic                    adc_on_q   = 1'b0;
  logic                    adc_sclk_q = 1'b0;
  logic [`N_DAC_BUSES-1:0] dac_on_q   = '0;
  logic [`N_DAC_BUSES-1:0] dac_sclk_q = '1;
  logic                    adc_on;
  logic [`N_DAC_BUSES-1:0] dac_on;

  assign o_adc_sdout = sdout_q;
  assign o_err_cnt   = err_cnt;
  assign adc_on      = (i_adc_sen_n != '1);

  // a bus counts as selected while any of its syncs is low
  always_comb begin
    for (int b = 0; b < `N_DAC_BUSES; b++) begin
      dac_on[b] = (i_dac_sync_n[b*`N_DAC_CHIPS +: `N_DAC_CHIPS] != '1);
    end
  end

  // pins sampled mid cycle, edges found against the previous sample
  always @(negedge lclk) begin
    adc_on_q   <= adc_on;
    adc_sclk_q <= i_adc_sclk;
    dac_on_q   <= dac_on;
    dac_sclk_q <= i_dac_sclk;
    if (adc_on && !adc_on_q) begin
      // enable just fell, MSB of the response goes out
      o_adc_sen_seen <= i_adc_sen_n;
      o_adc_rx       <= '0;
      o_adc_edges    <= '0;
      rd_idx         <= 0;
      sdout_q        <= i_adc_resp[`ADC_WORD_BITS-1];
    end else if (adc_on && i_adc_sclk && !adc_sclk_q) begin
      o_adc_rx    <= {o_adc_rx[`ADC_WORD_BITS-2:0], i_adc_sdata};
      o_adc_edges <= o_adc_edges + 8'd1;
    end else if (adc_on && !i_adc_sclk && adc_sclk_q) begin
      // next response bit after each falling edge
      rd_idx  <= rd_idx + 1;
      sdout_q <= (rd_idx < `ADC_WORD_BITS - 1) ? i_adc_resp[`ADC_WORD_BITS-2-rd_idx] : 1'b0;
    end
    for (int b = 0; b < `N_DAC_BUSES; b++) begin
      if (dac_on[b] && !dac_on_q[b]) begin
        o_dac_sync_seen <= i_dac_sync_n;
        o_dac_rx[b]     <= '0;
        o_dac_edges[b]  <= '0;
      end else if (dac_on[b] && !i_dac_sclk[b] && dac_sclk_q[b]) begin
        // AD5668 latches on the falling edge
        o_dac_rx[b]    <= {o_dac_rx[b][`DAC_WORD_BITS-2:0], i_dac_din[b]};
        o_dac_edges[b] <= o_dac_edges[b] + 8'd1;
      end
    end
  end

  // pin rules, checked every cycle
  always @(negedge lclk) begin
    assert ($countones(~i_adc_sen_n) <= 1) else begin
      err_cnt++;
      $display("at %0t more than one ADC enable is low", $time);
    end
    assert (adc_on || (!i_adc_sclk && !i_adc_sdata)) else begin
      err_cnt++;
      $display("at %0t the ADC clock or data moved with no enable low", $time);
    end
    assert (!(adc_on && dac_on != '0)) else begin
      err_cnt++;
      $display("at %0t an ADC enable and a DAC sync are low together", $time);
    end
    for (int b = 0; b < `N_DAC_BUSES; b++) begin
      assert (dac_on[b] || (i_dac_sclk[b] && !i_dac_din[b])) else begin
        err_cnt++;
        $display("at %0t DAC bus %0d is not idle while no sync is low", $time, b);
      end
    end
  end

endmodule

//--- design/slow_ctrl_top.sv
/*
 * slow serial control top
 * ADC3424 and AD5668 configuration through one shared shift engine
 */
`include "slow_ctrl_consts.svh"

module slow_ctrl_top (
  input  logic                                 lclk,
  input  logic                                 lclk_rst,
  // ADC client and pins
  input  logic                                 i_adc_req,
  input  logic [`N_ADC_CHIPS-1:0]              i_adc_sel,
  input  logic [`ADC_WORD_BITS-1:0]            i_adc_wr_data,
  input  logic                                 i_adc_sdout,
  output logic                                 o_adc_ack,
  output logic [`ADC_RD_BITS-1:0]              o_adc_rd_data,
  output logic                                 o_adc_sclk,
  output logic                                 o_adc_sdata,
  output logic [`N_ADC_CHIPS-1:0]              o_adc_sen_n,
  // DAC client and pins
  input  logic                                 i_dac_req,
  input  logic [`N_DAC_BUSES-1:0]              i_dac_bus_sel,
  input  logic [`N_DAC_CHIPS-1:0]              i_dac_chip_sel,
  input  logic [`DAC_WORD_BITS-1:0]            i_dac_wr_data,
  output logic                                 o_dac_ack,
  output logic [`N_DAC_BUSES-1:0]              o_dac_sclk,
  output logic [`N_DAC_BUSES-1:0]              o_dac_din,
  output logic [`N_DAC_BUSES*`N_DAC_CHIPS-1:0] o_dac_sync_n
);

  // arbiter to engine
  logic                          start;
  logic [`MAX_WORD_BITS-1:0]     word;
  logic [`BIT_CNT_W-1:0]         nbits;
  // engine to arbiter
  logic                          done;
  logic [`MAX_WORD_BITS-1:0]     rx_word;
  // arbiter to router
  logic                          busy;
  slow_ctrl_pkg::serial_target_e target;
  logic [`N_ADC_CHIPS-1:0]       adc_sel;
  logic [`N_DAC_BUSES-1:0]       dac_bus_sel;
  logic [`N_DAC_CHIPS-1:0]       dac_chip_sel;
  // engine to router
  logic                          frame;
  logic                          sclk_raw;
  logic                          mosi;

  serial_req_arbiter u_arbiter (
    .lclk           (lclk),
    .lclk_rst       (lclk_rst),
    .i_adc_req      (i_adc_req),
    .i_adc_sel      (i_adc_sel),
    .i_adc_wr_data  (i_adc_wr_data),
    .o_adc_ack      (o_adc_ack),
    .o_adc_rd_data  (o_adc_rd_data),
    .i_dac_req      (i_dac_req),
    .i_dac_bus_sel  (i_dac_bus_sel),
    .i_dac_chip_sel (i_dac_chip_sel),
    .i_dac_wr_data  (i_dac_wr_data),
    .o_dac_ack      (o_dac_ack),
    .i_done         (done),
    .i_rx_word      (rx_word),
    .o_start        (start),
    .o_word         (word),
    .o_nbits        (nbits),
    .o_busy         (busy),
    .o_target       (target),
    .o_adc_sel      (adc_sel),
    .o_dac_bus_sel  (dac_bus_sel),
    .o_dac_chip_sel (dac_chip_sel)
  );

  // only the ADC bus has a readback line
  spi_shift_engine u_engine (
    .lclk       (lclk),
    .lclk_rst   (lclk_rst),
    .i_start    (start),
    .i_word     (word),
    .i_nbits    (nbits),
    .i_miso     (i_adc_sdout),
    .o_frame    (frame),
    .o_sclk_raw (sclk_raw),
    .o_mosi     (mosi),
    .o_done     (done),
    .o_rx_word  (rx_word)
  );

  serial_pin_router u_router (
    .lclk           (lclk),
    .lclk_rst       (lclk_rst),
    .i_busy         (busy),
    .i_target       (target),
    .i_adc_sel      (adc_sel),
    .i_dac_bus_sel  (dac_bus_sel),
    .i_dac_chip_sel (dac_chip_sel),
    .i_frame        (frame),
    .i_sclk_raw     (sclk_raw),
    .i_mosi         (mosi),
    .o_adc_sclk     (o_adc_sclk),
    .o_adc_sdata    (o_adc_sdata),
    .o_adc_sen_n    (o_adc_sen_n),
    .o_dac_sclk     (o_dac_sclk),
    .o_dac_din      (o_dac_din),
    .o_dac_sync_n   (o_dac_sync_n)
  );

endmodule

//--- design/serial_pin_router.sv
/*
 * serial pin router
 * steers engine clock and data to the shared ADC bus or one DAC bus,
 * inverts the DAC clock and drives enables and syncs, all registered
 */
`include "slow_ctrl_consts.svh"

module serial_pin_router (
  input  logic                                    lclk,
  input  logic                                    lclk_rst,
  input  logic                                    i_busy,
  input  slow_ctrl_pkg::serial_target_e           i_target,
  input  logic [`N_ADC_CHIPS-1:0]                 i_adc_sel,
  input  logic [`N_DAC_BUSES-1:0]                 i_dac_bus_sel,
  input  logic [`N_DAC_CHIPS-1:0]                 i_dac_chip_sel,
  input  logic                                    i_frame,
  input  logic                                    i_sclk_raw,
  input  logic                                    i_mosi,
  output logic                                    o_adc_sclk,
  output logic                                    o_adc_sdata,
  output logic [`N_ADC_CHIPS-1:0]                 o_adc_sen_n,
  output logic [`N_DAC_BUSES-1:0]                 o_dac_sclk,
  output logic [`N_DAC_BUSES-1:0]                 o_dac_din,
  output logic [`N_DAC_BUSES*`N_DAC_CHIPS-1:0]    o_dac_sync_n
);

  logic                    adc_active;
  logic                    dac_active;
  logic [`N_DAC_BUSES-1:0] bus_on;

  // frame alone is not enough, busy keeps target and selects valid
  assign adc_active = i_busy && i_frame && (i_target == slow_ctrl_pkg::TARGET_ADC);
  assign dac_active = i_busy && i_frame && (i_target == slow_ctrl_pkg::TARGET_DAC);
  assign bus_on     = {`N_DAC_BUSES{dac_active}} & i_dac_bus_sel;

  // ADC side, clock idles low
  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      o_adc_sclk  <= 1'b0;
      o_adc_sdata <= 1'b0;
      o_adc_sen_n <= '1;
    end else begin
      o_adc_sclk  <= adc_active && i_sclk_raw;
      o_adc_sdata <= adc_active && i_mosi;
      o_adc_sen_n <= ~({`N_ADC_CHIPS{adc_active}} & i_adc_sel);
    end
  end

  // DAC buses, clock idles high
  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      o_dac_sclk   <= '1;
      o_dac_din    <= '0;
      o_dac_sync_n <= '1;
    end else begin
      for (int b = 0; b < `N_DAC_BUSES; b++) begin
        // inverted so the chip latches on its falling edge
        o_dac_sclk[b] <= !(bus_on[b] && i_sclk_raw);
        o_dac_din[b]  <= bus_on[b] && i_mosi;
        // bus-major sync lines
        o_dac_sync_n[b*`N_DAC_CHIPS +: `N_DAC_CHIPS] <=
          ~({`N_DAC_CHIPS{bus_on[b]}} & i_dac_chip_sel);
      end
    end
  end

endmodule

//--- design/spi_shift_engine.sv
/*
 * serial shift engine
 * runs one frame per start pulse: lead time, n clock periods with
 * MSB-first data out and sampling in, then tail time and done
 */
`include "slow_ctrl_consts.svh"

module spi_shift_engine (
  input  logic                      lclk,
  input  logic                      lclk_rst,
  input  logic                      i_start,
  input  logic [`MAX_WORD_BITS-1:0] i_word,
  input  logic [`BIT_CNT_W-1:0]     i_nbits,
  input  logic                      i_miso,
  output logic                      o_frame,
  output logic                      o_sclk_raw,
  output logic                      o_mosi,
  output logic                      o_done,
  output logic [`MAX_WORD_BITS-1:0] o_rx_word
);

  // one counter covers lead, tail and the bit period phase
  localparam int CNT_W = $clog2(`CS_LEAD + `CS_TAIL + 2 * `SCLK_HALF);

  slow_ctrl_pkg::spi_state_e state;

  logic [CNT_W-1:0]          cnt;
  logic [`BIT_CNT_W-1:0]     bit_cnt;
  logic [`BIT_CNT_W-1:0]     nbits;
  logic [`MAX_WORD_BITS-1:0] tx_shreg;
  logic                      lead_end;
  logic                      phase_end;
  logic                      phase_mid;
  logic                      phase_rise;
  logic                      tail_end;
  logic                      last_bit;

  // counter decodes
  assign lead_end   = (cnt == CNT_W'(`CS_LEAD - 1));
  assign tail_end   = (cnt == CNT_W'(`CS_TAIL - 1));
  assign phase_end  = (cnt == CNT_W'(2 * `SCLK_HALF - 1));
  // sclk falls after this cycle
  assign phase_mid  = (cnt == CNT_W'(`SCLK_HALF - 1));
  // first cycle of the high half
  assign phase_rise = (cnt == '0);
  assign last_bit   = (bit_cnt == nbits - `BIT_CNT_W'(1));

  // FSM and counters
  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      state   <= slow_ctrl_pkg::ST_IDLE;
      cnt     <= '0;
      bit_cnt <= '0;
    end else begin
      case (state)
        slow_ctrl_pkg::ST_IDLE: begin
          if (i_start) begin
            state   <= slow_ctrl_pkg::ST_LEAD;
            cnt     <= '0;
            bit_cnt <= '0;
          end
        end
        slow_ctrl_pkg::ST_LEAD: begin
          if (lead_end) begin
            state <= slow_ctrl_pkg::ST_SHIFT;
            cnt   <= '0;
          end else begin
            cnt <= cnt + CNT_W'(1);
          end
        end
        slow_ctrl_pkg::ST_SHIFT: begin
          if (phase_end) begin
            cnt     <= '0;
            bit_cnt <= bit_cnt + `BIT_CNT_W'(1);
            if (last_bit) begin
              state <= slow_ctrl_pkg::ST_TAIL;
            end
          end else begin
            cnt <= cnt + CNT_W'(1);
          end
        end
        slow_ctrl_pkg::ST_TAIL: begin
          if (tail_end) begin
            state <= slow_ctrl_pkg::ST_DONE;
            cnt   <= '0;
          end else begin
            cnt <= cnt + CNT_W'(1);
          end
        end
        // one recovery cycle before the next start is accepted
        slow_ctrl_pkg::ST_DONE: begin
          state <= slow_ctrl_pkg::ST_IDLE;
        end
        default: begin
          state <= slow_ctrl_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // shift registers, loaded on start
  always_ff @(posedge lclk) begin
    if (state == slow_ctrl_pkg::ST_IDLE && i_start) begin
      tx_shreg  <= i_word;
      nbits     <= i_nbits;
      o_rx_word <= '0;
    end else if (state == slow_ctrl_pkg::ST_SHIFT) begin
      // next bit goes out on the falling half
      if (phase_mid) begin
        tx_shreg <= tx_shreg << 1;
      end
      // capture lines up with the registered pin edge
      if (phase_rise) begin
        o_rx_word <= {o_rx_word[`MAX_WORD_BITS-2:0], i_miso};
      end
    end
  end

  // outputs decoded from registered state
  assign o_frame    = (state == slow_ctrl_pkg::ST_LEAD) ||
                      (state == slow_ctrl_pkg::ST_SHIFT) ||
                      (state == slow_ctrl_pkg::ST_TAIL);
  assign o_sclk_raw = (state == slow_ctrl_pkg::ST_SHIFT) && (cnt < CNT_W'(`SCLK_HALF));
  assign o_mosi     = tx_shreg[`MAX_WORD_BITS-1];
  // last tail cycle, exactly one frame after start
  assign o_done     = (state == slow_ctrl_pkg::ST_TAIL) && tail_end;

endmodule

//--- design/serial_req_arbiter.sv
/*
 * serial request arbiter
 * takes level requests from the ADC and DAC clients, grants one at a
 * time (ADC first), holds word and selects for the frame, pulses acks
 * and keeps the ADC read data
 */
`include "slow_ctrl_consts.svh"

module serial_req_arbiter (
  input  logic                               lclk,
  input  logic                               lclk_rst,
  // ADC client
  input  logic                               i_adc_req,
  input  logic [`N_ADC_CHIPS-1:0]            i_adc_sel,
  input  logic [`ADC_WORD_BITS-1:0]          i_adc_wr_data,
  output logic                               o_adc_ack,
  output logic [`ADC_RD_BITS-1:0]            o_adc_rd_data,
  // DAC client
  input  logic                               i_dac_req,
  input  logic [`N_DAC_BUSES-1:0]            i_dac_bus_sel,
  input  logic [`N_DAC_CHIPS-1:0]            i_dac_chip_sel,
  input  logic [`DAC_WORD_BITS-1:0]          i_dac_wr_data,
  output logic                               o_dac_ack,
  // shift engine
  input  logic                               i_done,
  input  logic [`MAX_WORD_BITS-1:0]          i_rx_word,
  output logic                               o_start,
  output logic [`MAX_WORD_BITS-1:0]          o_word,
  output logic [`BIT_CNT_W-1:0]              o_nbits,
  // pin router
  output logic                               o_busy,
  output slow_ctrl_pkg::serial_target_e      o_target,
  output logic [`N_ADC_CHIPS-1:0]            o_adc_sel,
  output logic [`N_DAC_BUSES-1:0]            o_dac_bus_sel,
  output logic [`N_DAC_CHIPS-1:0]            o_dac_chip_sel
);

  logic adc_pend;
  logic dac_pend;
  logic launch_adc;
  logic launch_dac;

  // a request still held in the ack cycle is already served
  assign adc_pend = i_adc_req && !o_adc_ack;
  assign dac_pend = i_dac_req && !o_dac_ack;

  // ADC has priority
  assign launch_adc = !o_busy && adc_pend;
  assign launch_dac = !o_busy && !adc_pend && dac_pend;

  // grant, busy and ack control
  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      o_busy         <= 1'b0;
      o_start        <= 1'b0;
      o_adc_ack      <= 1'b0;
      o_dac_ack      <= 1'b0;
      o_target       <= slow_ctrl_pkg::TARGET_ADC;
      o_adc_sel      <= '0;
      o_dac_bus_sel  <= '0;
      o_dac_chip_sel <= '0;
      o_adc_rd_data  <= '0;
    end else begin
      // single-cycle pulses
      o_start   <= 1'b0;
      o_adc_ack <= 1'b0;
      o_dac_ack <= 1'b0;

      if (launch_adc) begin
        o_busy    <= 1'b1;
        o_start   <= 1'b1;
        o_target  <= slow_ctrl_pkg::TARGET_ADC;
        o_adc_sel <= i_adc_sel;
      end else if (launch_dac) begin
        o_busy         <= 1'b1;
        o_start        <= 1'b1;
        o_target       <= slow_ctrl_pkg::TARGET_DAC;
        o_dac_bus_sel  <= i_dac_bus_sel;
        o_dac_chip_sel <= i_dac_chip_sel;
      end else if (o_busy && i_done) begin
        o_busy <= 1'b0;
        if (o_target == slow_ctrl_pkg::TARGET_ADC) begin
          o_adc_ack     <= 1'b1;
          // last bits shifted in are the register contents
          o_adc_rd_data <= i_rx_word[`ADC_RD_BITS-1:0];
        end else begin
          o_dac_ack <= 1'b1;
        end
      end
    end
  end

  // transfer word, MSB aligned for the engine
  always_ff @(posedge lclk) begin
    if (launch_adc) begin
      o_word  <= `MAX_WORD_BITS'(i_adc_wr_data) << (`MAX_WORD_BITS - `ADC_WORD_BITS);
      o_nbits <= `BIT_CNT_W'(`ADC_WORD_BITS);
    end else if (launch_dac) begin
      o_word  <= `MAX_WORD_BITS'(i_dac_wr_data) << (`MAX_WORD_BITS - `DAC_WORD_BITS);
      o_nbits <= `BIT_CNT_W'(`DAC_WORD_BITS);
    end
  end

endmodule

//--- design/slow_ctrl_pkg.sv
/*
 * slow control package
 * enums shared by the serial request arbiter, shift engine and pin router
 */
package slow_ctrl_pkg;

  // which client owns the current frame
  typedef enum logic {
    TARGET_ADC = 1'b0,
    TARGET_DAC = 1'b1
  } serial_target_e;

  // shift engine FSM
  typedef enum logic [2:0] {
    ST_IDLE  = 3'd0,
    ST_LEAD  = 3'd1,
    ST_SHIFT = 3'd2,
    ST_TAIL  = 3'd3,
    ST_DONE  = 3'd4
  } spi_state_e;

endpackage

//--- design/slow_ctrl_consts.svh
/*
 * slow control constants
 * word sizes, chip counts and serial frame timing shared by the
 * ADC3424 / AD5668 serial control path
 */
`ifndef SLOW_CTRL_CONSTS_SVH
`define SLOW_CTRL_CONSTS_SVH

// transfer sizes
`define ADC_WORD_BITS 24
`define ADC_RD_BITS 8
`define DAC_WORD_BITS 32
// word path, MSB aligned
`define MAX_WORD_BITS 32

// board population
`define N_ADC_CHIPS 6
`define N_DAC_BUSES 3
`define N_DAC_CHIPS 3

// serial timing, in lclk cycles
`define SCLK_HALF 4
`define CS_LEAD 8
`define CS_TAIL 8

// holds counts up to MAX_WORD_BITS
`define BIT_CNT_W 6

`endif
